//--- common/umi_pkg.sv
// ##########################################################
// Sizes and types shared by the UMI switch blocks
// Output port is chosen by destination bit DST_LSB alone
// ##########################################################
package umi_pkg;

   // ##########################################################
   // Switch dimensions
   // ##########################################################

   localparam int NUM_IN  = 4;              // Requesters
   localparam int NUM_OUT = 2;              // Output ports
   localparam int UW      = 64;             // UMI transaction width

   // Round-robin pointer width
   localparam int PTR_W   = $clog2(NUM_IN);

   // ##########################################################
   // Packet fields
   // ##########################################################

   // Lowest destination bit
   // Only this bit steers the packet, the rest of the field is ignored
   localparam int DST_LSB = 56;

   // Whole UMI transaction, opaque to the switch
   typedef logic [UW-1:0] umi_packet_t;

   // One bit per requester
   // Shared by valid, ready, mask and grant vectors
   typedef logic [NUM_IN-1:0] in_vec_t;

   // ##########################################################
   // Arbiter modes
   // ##########################################################

   // Plain 2-bit code so that unused codes stay legal
   typedef logic [1:0] arb_mode_t;

   localparam arb_mode_t ARB_FIXED = 2'd0;  // Input 0 highest
   localparam arb_mode_t ARB_RR    = 2'd1;  // Rotating start point
   // Codes 2 and 3 fall back to fixed priority

endpackage

//--- hw/umi_decode.sv
// ##########################################################
// Routes each request by destination bit, merges readies back
// ##########################################################
module umi_decode
  (
   input  umi_pkg::in_vec_t     in_valid,                     // Requester valids
   input  umi_pkg::umi_packet_t in_packet [umi_pkg::NUM_IN],  // Requester packets
   output umi_pkg::in_vec_t     req [umi_pkg::NUM_OUT],       // Valids seen by each port
   input  umi_pkg::in_vec_t     mux_ready [umi_pkg::NUM_OUT], // Readies from each port
   output umi_pkg::in_vec_t     in_ready                      // Back to requesters
   );

   import umi_pkg::*;

   // One-hot output select per input
   logic [NUM_OUT-1:0] target [NUM_IN];

   // ##########################################################
   // Destination decode
   // ##########################################################

   always_comb
   begin
      for (int i = 0; i < NUM_IN; i++)
      begin
         // Destination bit picks the port
         target[i] = NUM_OUT'(1) << in_packet[i][DST_LSB];
      end
   end

   // ##########################################################
   // Request fan-out
   // ##########################################################

   always_comb
   begin
      for (int o = 0; o < NUM_OUT; o++)
      begin
         for (int i = 0; i < NUM_IN; i++)
         begin
            req[o][i] = in_valid[i] & target[i][o]; // Only the target port sees it
         end
      end
   end

   // ##########################################################
   // Ready merge
   // ##########################################################

   // Each input closes its handshake against its own target only
   always_comb
   begin
      in_ready = '0;
      for (int i = 0; i < NUM_IN; i++)
      begin
         for (int o = 0; o < NUM_OUT; o++)
         begin
            in_ready[i] = in_ready[i] | (target[i][o] & mux_ready[o][i]);
         end
      end
   end

endmodule

//--- umi_mux/umi_arbiter.sv
// ##########################################################
// One-hot grant over unmasked requests, fixed or round robin
// Pointer moves on every accepted grant in either mode
// ##########################################################
module umi_arbiter
  (
   input  logic               clk,
   input  logic               rst,        // Sync, active high
   input  umi_pkg::arb_mode_t mode,       // ARB_FIXED or ARB_RR
   input  umi_pkg::in_vec_t   mask,       // 1 blocks the request
   input  umi_pkg::in_vec_t   in_valid,   // Raw requests
   input  logic               out_ready,  // Downstream accepts
   output umi_pkg::in_vec_t   grant       // One-hot winner
   );

   import umi_pkg::*;

   in_vec_t          req;        // Masked requests
   logic             rr_mode;
   logic             hit;        // Something to grant
   logic             accept;     // Granted and taken this cycle
   logic [PTR_W-1:0] ptr;        // Round-robin start index
   logic [PTR_W-1:0] win_fixed;
   logic [PTR_W-1:0] win_rr;
   logic [PTR_W-1:0] win_idx;

   assign req     = in_valid & ~mask;
   assign rr_mode = (mode == ARB_RR);   // Codes 2 and 3 act as fixed
   assign hit     = |req;

   // ##########################################################
   // Winner search
   // ##########################################################

   // Lowest index wins, so scan from the top down
   always_comb
   begin
      win_fixed = '0;
      for (int i = NUM_IN-1; i >= 0; i--)
      begin
         if (req[i])
            win_fixed = PTR_W'(i);
      end
   end

   // Same scan but offset from the pointer with wrap
   always_comb
   begin : rr_scan
      int idx;
      win_rr = '0;
      for (int k = NUM_IN-1; k >= 0; k--)
      begin
         idx = int'(ptr) + k;
         if (idx >= NUM_IN)
            idx = idx - NUM_IN;   // Wrap past last input
         if (req[idx])
            win_rr = PTR_W'(idx);
      end
   end

   assign win_idx = rr_mode ? win_rr : win_fixed;

   // Zero grant when nothing is requesting
   assign grant = hit ? (in_vec_t'(1) << win_idx) : '0;

   // ##########################################################
   // Round-robin pointer
   // ##########################################################

   assign accept = hit & out_ready;

   always_ff @(posedge clk)
   begin
      if (rst)
         ptr <= '0;                               // Start at input 0
      else if (accept)
      begin
         if (win_idx == PTR_W'(NUM_IN-1))
            ptr <= '0;                            // Wrap to input 0
         else
            ptr <= win_idx + PTR_W'(1);           // Next after winner
      end
      // Back-pressure holds the pointer
   end

endmodule

//--- umi_mux/umi_mux.sv
// ##########################################################
// Arbitrating UMI mux, input to output is combinational
// ##########################################################
module umi_mux
  (
   // Controls
   input  logic                 clk,
   input  logic                 rst,
   input  umi_pkg::arb_mode_t   mode,                         // Arbiter mode
   input  umi_pkg::in_vec_t     mask,                         // 1 disables input
   // Incoming UMI
   input  umi_pkg::in_vec_t     in_valid,
   output umi_pkg::in_vec_t     in_ready,
   input  umi_pkg::umi_packet_t in_packet [umi_pkg::NUM_IN],
   // Outgoing UMI
   output logic                 out_valid,
   output umi_pkg::umi_packet_t out_packet,
   input  logic                 out_ready
   );

   import umi_pkg::*;

   in_vec_t grant;   // One-hot winner from arbiter

   // ##########################################################
   // Valid selection
   // ##########################################################

   umi_arbiter i_arbiter
     (
      .clk       (clk),
      .rst       (rst),
      .mode      (mode),
      .mask      (mask),
      .in_valid  (in_valid),
      .out_ready (out_ready),
      .grant     (grant)
      );

   assign out_valid = |grant;

   // ##########################################################
   // Ready pushback
   // ##########################################################

   // Only the winner sees ready, and only when downstream takes it
   assign in_ready = grant & {NUM_IN{out_ready}};

   // ##########################################################
   // Packet mux
   // ##########################################################

   // AND-OR select, zero when nothing granted
   always_comb
   begin
      out_packet = '0;
      for (int i = 0; i < NUM_IN; i++)
      begin
         out_packet = out_packet | ({UW{grant[i]}} & in_packet[i]);
      end
   end

endmodule

//--- hw/umi_switch.sv
// ##########################################################
// 4 to 2 UMI switch without buffering
// mode and mask are shared by both output arbiters
// ##########################################################
module umi_switch
  (
   // Controls
   input  logic                        clk,
   input  logic                        rst,        // Sync, active high
   input  umi_pkg::arb_mode_t          mode,       // Shared arbiter mode
   input  umi_pkg::in_vec_t            mask,       // Shared request mask
   // Requesters
   input  umi_pkg::in_vec_t            in_valid,
   output umi_pkg::in_vec_t            in_ready,
   input  umi_pkg::umi_packet_t        in_packet [umi_pkg::NUM_IN],
   // Output ports
   output logic [umi_pkg::NUM_OUT-1:0] out_valid,
   input  logic [umi_pkg::NUM_OUT-1:0] out_ready,
   output umi_pkg::umi_packet_t        out_packet [umi_pkg::NUM_OUT]
   );

   import umi_pkg::*;

   // Per-port request and ready vectors
   in_vec_t req [NUM_OUT];        // Decoder to mux
   in_vec_t mux_ready [NUM_OUT];  // Mux back to decoder

   // ##########################################################
   // Destination decode
   // ##########################################################

   umi_decode i_decode
     (
      .in_valid  (in_valid),
      .in_packet (in_packet),
      .req       (req),
      .mux_ready (mux_ready),
      .in_ready  (in_ready)
      );

   // ##########################################################
   // Output ports
   // ##########################################################

   // Every port sees all packets, req decides which it may take
   for (genvar o = 0; o < NUM_OUT; o++)
   begin : g_port
      umi_mux i_mux
        (
         .clk        (clk),
         .rst        (rst),
         .mode       (mode),
         .mask       (mask),
         .in_valid   (req[o]),         // Only inputs aimed here
         .in_ready   (mux_ready[o]),
         .in_packet  (in_packet),
         .out_valid  (out_valid[o]),
         .out_packet (out_packet[o]),
         .out_ready  (out_ready[o])
         );
   end

endmodule

//--- sim/umi_switch_chk.sv
// ##########################################################
// Assertions on every umi_mux instance, inactive during reset
// ##########################################################
module umi_switch_chk
  (
   input logic             clk,
   input logic             rst,
   input umi_pkg::in_vec_t mask,
   input umi_pkg::in_vec_t in_valid,
   input umi_pkg::in_vec_t in_ready,
   input umi_pkg::in_vec_t grant,       // Arbiter winner
   input logic             out_valid
   );

   int fail_cnt = 0;   // Read by the testbench at the end

   // At most one requester handshakes per port
   ready_onehot : assert property (@(posedge clk) disable iff (rst) $onehot0(in_ready))
   else
   begin
      $error("in_ready has more than one bit set");
      fail_cnt++;
   end

   // Output only for a real request
   valid_granted : assert property (@(posedge clk) disable iff (rst)
                                    out_valid |-> |(grant & in_valid))
   else
   begin
      $error("out_valid without a valid granted input");
      fail_cnt++;
   end

   masked_no_ready : assert property (@(posedge clk) disable iff (rst)
                                      (in_ready & mask) == '0)
   else
   begin
      $error("masked input received ready");
      fail_cnt++;
   end

   idle_no_valid : assert property (@(posedge clk) disable iff (rst)
                                    (in_valid == '0) |-> !out_valid)
   else
   begin
      $error("out_valid high with no input valid");
      fail_cnt++;
   end

endmodule

bind umi_mux umi_switch_chk i_chk
  (
   .clk       (clk),
   .rst       (rst),
   .mask      (mask),
   .in_valid  (in_valid),
   .in_ready  (in_ready),
   .grant     (grant),
   .out_valid (out_valid)
   );

//--- sim/umi_switch_tb.sv
// ##########################################################
// Testbench for the UMI switch with table steps then random traffic
// Outputs sampled at the falling edge and inputs driven at rise + 2
// ##########################################################
module umi_switch_tb;

   import umi_pkg::*;

   localparam int         WAIT_LIMIT = 100;   // Time steps per clock wait
   localparam logic [2:0] NONE       = 3'd4;  // No winner expected
   localparam int         RAND_STEPS = 200;

   // One row of the stimulus table
   typedef struct packed {
      logic [2:0] test;
      arb_mode_t  mode;
      in_vec_t    mask;
      in_vec_t    valid;
      in_vec_t    dst;       // Destination bit per input
      logic [1:0] ready;     // out_ready per port
      logic [2:0] exp0;      // Winner on port 0 or NONE
      logic [2:0] exp1;      // Winner on port 1 or NONE
      in_vec_t    exp_rdy;
   } step_t;

   // DUT signals
   logic         clk;
   logic         rst;
   arb_mode_t    mode;
   in_vec_t      mask;
   in_vec_t      in_valid;
   in_vec_t      in_ready;
   umi_packet_t  in_packet [NUM_IN];
   logic [NUM_OUT-1:0] out_valid;
   logic [NUM_OUT-1:0] out_ready;
   umi_packet_t  out_packet [NUM_OUT];

   step_t        steps [$];
   in_vec_t      cur_dst;            // Destination bits now driven
   int           model_ptr [NUM_OUT];
   int           n_checks;
   int           n_errors;
   int           test_checks;        // Counters of the running test
   int           test_errors;
   bit           timed_out;

   umi_switch i_dut
     (
      .clk        (clk),
      .rst        (rst),
      .mode       (mode),
      .mask       (mask),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_packet  (in_packet),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_packet (out_packet)
      );

   initial clk = 1'b0;
   always #10 clk = ~clk;   // 20 unit period

   // ##########################################################
   // Reporting and run end
   // ##########################################################

   task automatic finish_run();
      int chk_fails;
      chk_fails = i_dut.g_port[0].i_mux.i_chk.fail_cnt + i_dut.g_port[1].i_mux.i_chk.fail_cnt;
      if (chk_fails != 0)
         $display("Assertion checker flagged %0d failures", chk_fails);
      $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, chk_fails);
      if (n_errors == 0 && chk_fails == 0 && !timed_out)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic report_test(input int t);
      string label;
      case (t)
         1:       label = "fixed priority";
         2:       label = "masking";
         3:       label = "destination routing";
         4:       label = "back-pressure";
         5:       label = "round robin";
         default: label = "random traffic";
      endcase
      $display("test %0d %s: %0d checks, %0d errors", t, label, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
   endtask

   task automatic note_result(input bit ok);
      n_checks++;
      test_checks++;
      if (!ok)
      begin
         n_errors++;
         test_errors++;
      end
   endtask

   // ##########################################################
   // Compare tasks
   // ##########################################################

   task automatic check_packet(input string what, input umi_pkg::umi_packet_t exp,
                               input umi_pkg::umi_packet_t act);
      note_result(exp === act);
      if (exp !== act)
         $display("ERR %0t %s: packet expected %h got %h", $time, what, exp, act);
   endtask

   task automatic check_ready(input string what, input umi_pkg::in_vec_t exp,
                              input umi_pkg::in_vec_t act);
      note_result(exp === act);
      if (exp !== act)
         $display("ERR %0t %s: in_ready expected %b got %b", $time, what, exp, act);
   endtask

   task automatic check_valid(input string what, input logic exp, input logic act);
      note_result(exp === act);
      if (exp !== act)
         $display("ERR %0t %s: out_valid expected %b got %b", $time, what, exp, act);
   endtask

   // ##########################################################
   // Clock waits
   // ##########################################################

   task automatic wait_level(input logic level);
      int cnt;
      cnt = 0;
      while (clk !== level && cnt < WAIT_LIMIT)
      begin
         #1;
         cnt++;
      end
      if (clk !== level)
      begin
         $display("Timeout: clock did not reach %b within %0d time steps", level, cnt);
         timed_out = 1'b1;
         finish_run();
      end
   endtask

   task automatic next_edge();
      wait_level(1'b0);
      wait_level(1'b1);   // Fresh rising edge
   endtask

   // ##########################################################
   // Stimulus and reference model
   // ##########################################################

   // Tagged payload with the destination bit in place
   function automatic umi_packet_t make_packet(input int tag, input int idx, input logic dst);
      return {7'(idx + 1), dst, 8'(tag), 48'h0123_4567_89AB ^ 48'(idx)};
   endfunction

   task automatic drive_step(input arb_mode_t m, input in_vec_t mk, input in_vec_t v,
                             input in_vec_t d, input logic [1:0] r, input int tag,
                             input bit rnd);
      umi_packet_t p;
      mode      = m;
      mask      = mk;
      in_valid  = v;
      out_ready = r;
      cur_dst   = d;
      for (int i = 0; i < NUM_IN; i++)
      begin
         if (rnd)
         begin
            p = {$urandom, $urandom};
            p[DST_LSB] = d[i];        // Route stays under test control
         end
         else
            p = make_packet(tag, i, d[i]);
         in_packet[i] = p;
      end
   endtask

   // Winner index or -1
   function automatic int pick(input arb_mode_t m, input in_vec_t req, input int ptr);
      int idx;
      for (int k = 0; k < NUM_IN; k++)
      begin
         idx = (m == ARB_RR) ? (ptr + k) % NUM_IN : k;   // Other codes act as fixed
         if (req[idx])
            return idx;
      end
      return -1;
   endfunction

   // Unmasked requests aimed at port o
   function automatic in_vec_t port_req(input int o);
      in_vec_t r;
      for (int i = 0; i < NUM_IN; i++)
         r[i] = in_valid[i] & ~mask[i] & (int'(cur_dst[i]) == o);
      return r;
   endfunction

   // Pointer moves past the winner on every accepted transfer
   task automatic advance_model();
      int w;
      for (int o = 0; o < NUM_OUT; o++)
      begin
         w = pick(mode, port_req(o), model_ptr[o]);
         if (w >= 0 && out_ready[o])
            model_ptr[o] = (w + 1) % NUM_IN;
      end
   endtask

   task automatic check_port(input int o, input int w, input string what);
      check_valid($sformatf("%s port %0d", what, o), w >= 0, out_valid[o]);
      check_packet($sformatf("%s port %0d", what, o), (w < 0) ? '0 : in_packet[w],
                   out_packet[o]);
   endtask

   task automatic add_step(input logic [2:0] t, input arb_mode_t m, input in_vec_t mk,
                           input in_vec_t v, input in_vec_t d, input logic [1:0] r,
                           input logic [2:0] e0, input logic [2:0] e1, input in_vec_t er);
      steps.push_back('{t, m, mk, v, d, r, e0, e1, er});
   endtask

   task automatic build_table();
      //       test mode       mask     valid    dst      rdy    win0  win1  in_ready
      add_step(1, ARB_FIXED, 4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd0, NONE, 4'b0001);
      add_step(1, ARB_FIXED, 4'b0000, 4'b1110, 4'b0000, 2'b11, 3'd1, NONE, 4'b0010);
      add_step(2, ARB_FIXED, 4'b0011, 4'b1111, 4'b0000, 2'b11, 3'd2, NONE, 4'b0100);
      add_step(2, ARB_FIXED, 4'b0110, 4'b0110, 4'b0000, 2'b11, NONE, NONE, 4'b0000);
      add_step(3, ARB_FIXED, 4'b0000, 4'b1111, 4'b1010, 2'b11, 3'd0, 3'd1, 4'b0011);
      add_step(3, ARB_FIXED, 4'b0000, 4'b1100, 4'b1000, 2'b11, 3'd2, 3'd3, 4'b1100);
      // Pointer of port 0 sits at 3 here
      add_step(4, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b00, 3'd3, NONE, 4'b0000);
      add_step(4, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b00, 3'd3, NONE, 4'b0000);
      add_step(4, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd3, NONE, 4'b1000);
      add_step(5, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd0, NONE, 4'b0001);
      add_step(5, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd1, NONE, 4'b0010);
      add_step(5, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd2, NONE, 4'b0100);
      add_step(5, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd3, NONE, 4'b1000);
      add_step(5, ARB_RR,    4'b0000, 4'b1111, 4'b0000, 2'b11, 3'd0, NONE, 4'b0001);
      add_step(5, ARB_RR,    4'b0000, 4'b1001, 4'b0000, 2'b11, 3'd3, NONE, 4'b1000); // Skips 1, 2
      add_step(5, ARB_RR,    4'b0000, 4'b1010, 4'b0000, 2'b11, 3'd1, NONE, 4'b0010);
      add_step(5, ARB_RR,    4'b0000, 4'b1111, 4'b1111, 2'b11, NONE, 3'd0, 4'b0001);
   endtask

   // ##########################################################
   // Main sequence
   // ##########################################################

   initial
   begin
      int          w;
      in_vec_t     exp_rdy;
      step_t       s;
      void'($urandom(32'ha04522f8));   // Single seed for the run
      rst         = 1'b1;
      mode        = ARB_FIXED;
      mask        = '0;
      in_valid    = '0;
      out_ready   = '0;
      cur_dst     = '0;
      n_checks    = 0;
      n_errors    = 0;
      test_checks = 0;
      test_errors = 0;
      timed_out   = 1'b0;
      for (int i = 0; i < NUM_IN; i++)
         in_packet[i] = '0;
      for (int o = 0; o < NUM_OUT; o++)
         model_ptr[o] = 0;
      build_table();

      for (int c = 0; c < 16; c++)
         next_edge();
      #2 rst = 1'b0;

      // Directed table
      for (int k = 0; k < steps.size(); k++)
      begin
         s = steps[k];
         next_edge();
         #2 drive_step(s.mode, s.mask, s.valid, s.dst, s.ready, k, 1'b0);
         wait_level(1'b0);   // Settled
         check_port(0, (s.exp0 == NONE) ? -1 : int'(s.exp0), $sformatf("step %0d", k));
         check_port(1, (s.exp1 == NONE) ? -1 : int'(s.exp1), $sformatf("step %0d", k));
         check_ready($sformatf("step %0d", k), s.exp_rdy, in_ready);
         advance_model();
         if (k == steps.size() - 1 || steps[k+1].test != s.test)
            report_test(s.test);
      end

      // Random traffic against the model
      for (int k = 0; k < RAND_STEPS; k++)
      begin
         next_edge();
         #2 drive_step(arb_mode_t'($urandom_range(3, 0)), in_vec_t'($urandom),
                       in_vec_t'($urandom), in_vec_t'($urandom), 2'($urandom), k, 1'b1);
         wait_level(1'b0);
         exp_rdy = '0;
         for (int o = 0; o < NUM_OUT; o++)
         begin
            w = pick(mode, port_req(o), model_ptr[o]);
            check_port(o, w, $sformatf("random %0d", k));
            if (w >= 0 && out_ready[o])
               exp_rdy[w] = 1'b1;
         end
         check_ready($sformatf("random %0d", k), exp_rdy, in_ready);
         advance_model();
      end
      report_test(6);

      finish_run();
   end

endmodule

//--- umi_switch.f
common/umi_pkg.sv
hw/umi_decode.sv
umi_mux/umi_arbiter.sv
umi_mux/umi_mux.sv
hw/umi_switch.sv
sim/umi_switch_chk.sv
sim/umi_switch_tb.sv

//--- Bender.yml
package:
  name: umi_switch

sources:
  # Design
  - common/umi_pkg.sv
  - hw/umi_decode.sv
  - umi_mux/umi_arbiter.sv
  - umi_mux/umi_mux.sv
  - hw/umi_switch.sv
  # Verification
  - target: simulation
    files:
      - sim/umi_switch_chk.sv
      - sim/umi_switch_tb.sv
